//--- colmix_pkg.sv
// ====================
// colour mixer package
// widths, delay depth and shadow marker of the mixer
// ====================
package colmix_pkg;

    // palette ram geometry
    localparam int pal_aw = 11;               // 2048 entries
    localparam int pal_dw = 16;               // bit 15 shadow enable, then b/g/r

    // palette index below the obj/tile select bit
    localparam int idx_w = pal_aw - 1;

    // layer candidate with the shadow flag above the palette address
    localparam int lyr_w = pal_aw + 1;

    // output channels
    localparam int rgb_w = 5;
    localparam int col_w = 3 * rgb_w;         // {blue, green, red}

    // pixel code widths coming from the generators
    localparam int char_w = 7;                // prio bit and 6 bit colour
    localparam int scr_w  = 11;               // prio bit and 10 bit colour
    localparam int obj_w  = 12;               // 2 prio bits and 10 bit colour

    // colour and blanking pipe depth in pxl_cen steps
    localparam int blank_dly = 2;

    // object colour bits 9:4 all set marks a shadow sprite
    localparam logic [5:0] shadow_code = 6'h3f;

endpackage

//--- layer_prio.sv
// ====================
// layer priority
// gates the four layers, resolves object vs tile per layer
// and picks the palette address of the front opaque layer
// ====================
module layer_prio (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    input  logic [3:0]                    gfx_en,    // char, scr1, scr2, obj
    input  logic [colmix_pkg::char_w-1:0] char_pxl,
    input  logic [colmix_pkg::scr_w-1:0]  scr1_pxl,
    input  logic [colmix_pkg::scr_w-1:0]  scr2_pxl,
    input  logic [colmix_pkg::obj_w-1:0]  obj_pxl,
    output logic [colmix_pkg::pal_aw-1:0] pal_addr,
    output logic                          shadow
);
    import colmix_pkg::*;

    // gated pixel codes
    logic [char_w-1:0] char_g;
    logic [scr_w-1:0]  scr1_g;
    logic [scr_w-1:0]  scr2_g;
    logic [obj_w-1:0]  obj_g;

    logic [1:0]        obj_prio;
    logic [idx_w-1:0]  char_idx;                 // char colour widened to palette index

    // registered candidates, one per tile layer
    // {shadow, is_obj, index}
    logic [lyr_w-1:0]  lyr0;
    logic [lyr_w-1:0]  lyr1;
    logic [lyr_w-1:0]  lyr2;

    // object wins over the tile unless the tile is in front
    function automatic logic [lyr_w-1:0] tile_or_obj(
        input logic [idx_w-1:0] obj,
        input logic [idx_w-1:0] tile,
        input logic             tile_prio,
        input logic             obj_high
    );
        logic keep_tile;
        keep_tile = (obj[3:0] == 4'd0) || tile_prio || !obj_high;
        if (keep_tile)
            return {2'b00, tile};
        else if (obj[9:4] == shadow_code)
            return {2'b10, tile};                // tile stays but darkened
        else
            return {2'b01, obj};
    endfunction

    // objects use the whole nibble for opacity and tiles only 3 bits
    function automatic logic opaque(input logic [lyr_w-1:0] c);
        return c[idx_w] ? (c[3:0] != 4'd0) : (c[2:0] != 3'd0);
    endfunction

    // transparent colour = low nibble cleared
    always_comb begin
        char_g = char_pxl;
        scr1_g = scr1_pxl;
        scr2_g = scr2_pxl;
        obj_g  = obj_pxl;
        if (!gfx_en[0]) char_g[3:0] = 4'd0;
        if (!gfx_en[1]) scr1_g[3:0] = 4'd0;
        if (!gfx_en[2]) scr2_g[3:0] = 4'd0;
        if (!gfx_en[3]) obj_g[3:0]  = 4'd0;
    end

    assign obj_prio = obj_g[obj_w-1 -: 2];
    assign char_idx = {{(idx_w-char_w+1){1'b0}}, char_g[char_w-2:0]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lyr0 <= '0;
            lyr1 <= '0;
            lyr2 <= '0;
        end else if (pxl_cen) begin
            // char needs top object priority and scr2 any non-zero one
            lyr0 <= tile_or_obj(obj_g[idx_w-1:0], char_idx,
                                char_g[char_w-1], obj_prio == 2'd3);
            lyr1 <= tile_or_obj(obj_g[idx_w-1:0], scr1_g[idx_w-1:0],
                                scr1_g[scr_w-1], obj_prio >= 2'd2);
            lyr2 <= tile_or_obj(obj_g[idx_w-1:0], scr2_g[idx_w-1:0],
                                scr2_g[scr_w-1], obj_prio >= 2'd1);
        end
    end

    // front to back with scr2 as the backdrop
    always_comb begin
        if (opaque(lyr0))
            {shadow, pal_addr} = lyr0;
        else if (opaque(lyr1))
            {shadow, pal_addr} = lyr1;
        else
            {shadow, pal_addr} = lyr2;
    end

endmodule

//--- pal_ram.sv
// ====================
// palette ram
// dual port, byte writes from cpu, registered reads
// ====================
module pal_ram (
    input  logic                          clk,
    input  logic [1:0]                    we,          // per byte lane
    input  logic [colmix_pkg::pal_aw-1:0] cpu_addr,
    input  logic [colmix_pkg::pal_dw-1:0] cpu_dout,
    input  logic [colmix_pkg::pal_aw-1:0] video_addr,
    output logic [colmix_pkg::pal_dw-1:0] cpu_din,
    output logic [colmix_pkg::pal_dw-1:0] video_q
);
    import colmix_pkg::*;

    logic [pal_dw-1:0] mem [0:(1<<pal_aw)-1];

    // cpu port
    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (we[b])
                mem[cpu_addr][b*8 +: 8] <= cpu_dout[b*8 +: 8];   // lane b only
        end
        cpu_din <= mem[cpu_addr];              // old word on a write cycle
    end

    // video port, read only
    always_ff @(posedge clk) begin
        video_q <= mem[video_addr];
    end

endmodule

//--- shade_blank.sv
// ====================
// shade and blank
// shadow halving, video enable and the blanking delay line
// ====================
module shade_blank (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    input  logic                          video_en,
    input  logic                          shadow,      // from layer_prio for the pal_q pixel
    input  logic [colmix_pkg::pal_dw-1:0] pal_q,
    input  logic                          LHBL,
    input  logic                          LVBL,
    output logic [colmix_pkg::rgb_w-1:0]  red,
    output logic [colmix_pkg::rgb_w-1:0]  green,
    output logic [colmix_pkg::rgb_w-1:0]  blue,
    output logic                          LHBL_dly,
    output logic                          LVBL_dly
);
    import colmix_pkg::*;

    logic [col_w-1:0]     shaded;              // {b, g, r} before the pipe
    logic                 hb_s;                // flags taken with the pixel codes
    logic                 vb_s;
    logic [col_w-1:0]     col_q [blank_dly];
    logic [blank_dly-1:0] hb_q;
    logic [blank_dly-1:0] vb_q;

    always_comb begin
        shaded = pal_q[col_w-1:0];
        // shadow only bites on entries that allow it
        if (shadow && pal_q[pal_dw-1]) begin
            for (int i = 0; i < 3; i++)
                shaded[i*rgb_w +: rgb_w] = pal_q[i*rgb_w +: rgb_w] >> 1;
        end
        if (!video_en)
            shaded = '0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hb_s <= 1'b0;
            vb_s <= 1'b0;
            hb_q <= '0;                        // blanked out of reset
            vb_q <= '0;
            for (int i = 0; i < blank_dly; i++)
                col_q[i] <= '0;
        end else if (pxl_cen) begin
            hb_s <= LHBL;
            vb_s <= LVBL;
            // ram word is ready by the first stage
            col_q[0] <= (hb_s && vb_s) ? shaded : '0;
            hb_q[0]  <= hb_s;
            vb_q[0]  <= vb_s;
            for (int i = 1; i < blank_dly; i++) begin
                col_q[i] <= (hb_q[i-1] && vb_q[i-1]) ? col_q[i-1] : '0;
                hb_q[i]  <= hb_q[i-1];
                vb_q[i]  <= vb_q[i-1];
            end
        end
    end

    // last stage drives the pins
    assign {blue, green, red} = col_q[blank_dly-1];
    assign LHBL_dly = hb_q[blank_dly-1];
    assign LVBL_dly = vb_q[blank_dly-1];

endmodule

//--- colmix.sv
// ====================
// colour mixer top
// layer priority, palette ram and output blanking
// ====================
module colmix (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,     // every other clk at most
    input  logic                          video_en,
    input  logic [3:0]                    gfx_en,
    input  logic                          LHBL,
    input  logic                          LVBL,
    // cpu palette port
    input  logic                          pal_cs,
    input  logic [colmix_pkg::pal_aw:1]   cpu_addr,    // word address
    input  logic [colmix_pkg::pal_dw-1:0] cpu_dout,
    input  logic [1:0]                    dsn,         // active low byte strobes
    // pixel codes
    input  logic [colmix_pkg::char_w-1:0] char_pxl,
    input  logic [colmix_pkg::scr_w-1:0]  scr1_pxl,
    input  logic [colmix_pkg::scr_w-1:0]  scr2_pxl,
    input  logic [colmix_pkg::obj_w-1:0]  obj_pxl,
    output logic [colmix_pkg::pal_dw-1:0] cpu_din,
    output logic [colmix_pkg::rgb_w-1:0]  red,
    output logic [colmix_pkg::rgb_w-1:0]  green,
    output logic [colmix_pkg::rgb_w-1:0]  blue,
    output logic                          LHBL_dly,
    output logic                          LVBL_dly
);
    import colmix_pkg::*;

    logic [1:0]        we;
    logic [pal_aw-1:0] pal_addr;                 // winner's palette entry
    logic              shadow;
    logic [pal_dw-1:0] pal_q;

    assign we = ~dsn & {2{pal_cs}};              // lane write when selected

    layer_prio layer_prio_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .gfx_en   (gfx_en),
        .char_pxl (char_pxl),
        .scr1_pxl (scr1_pxl),
        .scr2_pxl (scr2_pxl),
        .obj_pxl  (obj_pxl),
        .pal_addr (pal_addr),
        .shadow   (shadow)
    );

    pal_ram pal_ram_i (
        .clk        (clk),
        .we         (we),
        .cpu_addr   (cpu_addr),
        .cpu_dout   (cpu_dout),
        .video_addr (pal_addr),
        .cpu_din    (cpu_din),
        .video_q    (pal_q)
    );

    shade_blank shade_blank_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .video_en (video_en),
        .shadow   (shadow),
        .pal_q    (pal_q),
        .LHBL     (LHBL),
        .LVBL     (LVBL),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .LHBL_dly (LHBL_dly),
        .LVBL_dly (LVBL_dly)
    );

endmodule

//--- colmix_properties.sv
// ====================
// colour mixer properties
// blanking, pixel rate and cpu readback rules
// ====================
module colmix_properties (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          pxl_cen,
    input logic                          pal_cs,
    input logic [1:0]                    dsn,
    input logic [colmix_pkg::pal_aw:1]   cpu_addr,
    input logic [colmix_pkg::pal_dw-1:0] cpu_din,
    input logic [colmix_pkg::rgb_w-1:0]  red,
    input logic [colmix_pkg::rgb_w-1:0]  green,
    input logic [colmix_pkg::rgb_w-1:0]  blue,
    input logic                          LHBL_dly,
    input logic                          LVBL_dly
);
    timeunit 1ns;
    timeprecision 100ps;

    logic cpu_wr;

    assign cpu_wr = pal_cs && (dsn != 2'b11);   // any lane written

    blank_black: assert property (@(posedge clk) disable iff (!rst_n)
        !(LHBL_dly && LVBL_dly) |-> ({red, green, blue} == '0))
        else $error("rgb not black while blanked");

    // outputs move only on the clk after a strobe
    pixel_rate: assert property (@(posedge clk) disable iff (!rst_n)
        !$past(pxl_cen) |-> $stable({red, green, blue, LHBL_dly, LVBL_dly}))
        else $error("video outputs changed without pxl_cen");

    readback_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(cpu_addr) == $past(cpu_addr, 2)) && !$past(cpu_wr) && !$past(cpu_wr, 2)
        |-> $stable(cpu_din))
        else $error("cpu_din changed with address and palette unchanged");

endmodule

bind colmix colmix_properties colmix_properties_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .pxl_cen  (pxl_cen),
    .pal_cs   (pal_cs),
    .dsn      (dsn),
    .cpu_addr (cpu_addr),
    .cpu_din  (cpu_din),
    .red      (red),
    .green    (green),
    .blue     (blue),
    .LHBL_dly (LHBL_dly),
    .LVBL_dly (LVBL_dly)
);

//--- colmix_tb.sv
// ====================
// colour mixer testbench
// seeded random pixels and cpu palette traffic
// checked against a reference model of the mixer
// ====================
module colmix_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import colmix_pkg::*;

    typedef struct packed {
        logic [rgb_w-1:0] r;
        logic [rgb_w-1:0] g;
        logic [rgb_w-1:0] b;
        logic             hb;
        logic             vb;
    } pix_t;

    localparam int cen_timeout = 8;          // clocks allowed between pxl_cen pulses

    logic              clk;
    logic              rst_n;
    logic              pxl_cen;
    logic              video_en;
    logic [3:0]        gfx_en;
    logic              LHBL;
    logic              LVBL;
    logic              pal_cs;
    logic [pal_aw:1]   cpu_addr;
    logic [pal_dw-1:0] cpu_dout;
    logic [1:0]        dsn;
    logic [char_w-1:0] char_pxl;
    logic [scr_w-1:0]  scr1_pxl;
    logic [scr_w-1:0]  scr2_pxl;
    logic [obj_w-1:0]  obj_pxl;
    logic [pal_dw-1:0] cpu_din;
    logic [rgb_w-1:0]  red;
    logic [rgb_w-1:0]  green;
    logic [rgb_w-1:0]  blue;
    logic              LHBL_dly;
    logic              LVBL_dly;

    logic [pal_dw-1:0] pal_model [0:(1<<pal_aw)-1];   // mirror of the palette
    pix_t              exp_q [$];            // expected pixels in flight
    pix_t              prev_raw;             // last pixel, video_en not yet known
    logic              have_prev;
    int                rgb_errors;
    int                word_errors;
    int                timeouts;

    colmix colmix_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .video_en (video_en),
        .gfx_en   (gfx_en),
        .LHBL     (LHBL),
        .LVBL     (LVBL),
        .pal_cs   (pal_cs),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .dsn      (dsn),
        .char_pxl (char_pxl),
        .scr1_pxl (scr1_pxl),
        .scr2_pxl (scr2_pxl),
        .obj_pxl  (obj_pxl),
        .cpu_din  (cpu_din),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .LHBL_dly (LHBL_dly),
        .LVBL_dly (LVBL_dly)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;               // 8 ns period
    end

    // pixel strobe on every second clk
    initial begin
        pxl_cen = 1'b0;
        forever begin
            @(posedge clk);
            pxl_cen <= ~pxl_cen;
        end
    end

    // odd multiplier so every address bit reaches the word
    function automatic logic [pal_dw-1:0] fill_word(input logic [pal_aw-1:0] a);
        logic [31:0] m;
        m = 32'(a) * 32'h9e37 + 32'h1357;
        return m[pal_dw-1:0];
    endfunction

    // priority pick and palette lookup with shadow but no blanking yet
    function automatic pix_t model_pixel(
        input logic [char_w-1:0] ch,
        input logic [scr_w-1:0]  s1,
        input logic [scr_w-1:0]  s2,
        input logic [obj_w-1:0]  ob,
        input logic [3:0]        en,
        input logic              hb,
        input logic              vb
    );
        logic [idx_w-1:0]  tile [3];
        logic              front [3];
        logic [1:0]        need [3];
        logic [idx_w-1:0]  ocol;
        logic [1:0]        oprio;
        logic [idx_w-1:0]  c_idx;
        logic              c_obj;
        logic              c_shade;
        logic              opq;
        logic              found;
        logic [idx_w-1:0]  idx;
        logic              is_obj;
        logic              shade;
        logic [pal_dw-1:0] w;
        pix_t              p;
        tile[0] = '0;
        tile[0][5:0] = en[0] ? ch[5:0] : {ch[5:4], 4'd0};   // disabled = clear nibble
        front[0] = ch[6];
        need[0] = 2'd3;
        tile[1] = en[1] ? s1[9:0] : {s1[9:4], 4'd0};
        front[1] = s1[10];
        need[1] = 2'd2;
        tile[2] = en[2] ? s2[9:0] : {s2[9:4], 4'd0};
        front[2] = s2[10];
        need[2] = 2'd1;
        ocol = en[3] ? ob[9:0] : {ob[9:4], 4'd0};
        oprio = ob[11:10];
        found = 1'b0;
        idx = '0;
        is_obj = 1'b0;
        shade = 1'b0;
        for (int l = 0; l < 3; l++) begin
            c_idx = tile[l];
            c_obj = 1'b0;
            c_shade = 1'b0;
            if (ocol[3:0] != 4'd0 && !front[l] && oprio >= need[l]) begin
                if (ocol[9:4] == shadow_code)
                    c_shade = 1'b1;          // tile kept but darkened
                else begin
                    c_obj = 1'b1;
                    c_idx = ocol;
                end
            end
            opq = c_obj ? (c_idx[3:0] != 4'd0) : (c_idx[2:0] != 3'd0);
            if (!found && (opq || l == 2)) begin   // scr2 is the backdrop
                found = 1'b1;
                idx = c_idx;
                is_obj = c_obj;
                shade = c_shade;
            end
        end
        w = pal_model[{is_obj, idx}];
        p.r = w[4:0];
        p.g = w[9:5];
        p.b = w[14:10];
        if (shade && w[15]) begin
            p.r = p.r >> 1;
            p.g = p.g >> 1;
            p.b = p.b >> 1;
        end
        p.hb = hb;
        p.vb = vb;
        return p;
    endfunction

    // black when video off or either flag low
    function automatic pix_t gate_pixel(input pix_t p, input logic ven);
        pix_t q;
        q = p;
        if (!ven || !p.hb || !p.vb) begin
            q.r = '0;
            q.g = '0;
            q.b = '0;
        end
        return q;
    endfunction

    task automatic check_rgb(
        input logic [rgb_w-1:0] exp_r,
        input logic [rgb_w-1:0] exp_g,
        input logic [rgb_w-1:0] exp_b,
        input logic             exp_hb,
        input logic             exp_vb
    );
        if ({red, green, blue, LHBL_dly, LVBL_dly} !== {exp_r, exp_g, exp_b, exp_hb, exp_vb}) begin
            rgb_errors++;
            $display("FAILED t=%0t rgb %h/%h/%h flags %b%b, expected %h/%h/%h flags %b%b",
                     $time, red, green, blue, LHBL_dly, LVBL_dly,
                     exp_r, exp_g, exp_b, exp_hb, exp_vb);
        end
    endtask

    task automatic check_word(
        input logic [pal_dw-1:0] got,
        input logic [pal_dw-1:0] expd,
        input logic [pal_aw-1:0] addr
    );
        if (got !== expd) begin
            word_errors++;
            $display("FAILED t=%0t readback at %h gave %h, expected %h", $time, addr, got, expd);
        end
    endtask

    task automatic finish_run();
        $display("rgb errors: %0d  readback errors: %0d  timeouts: %0d",
                 rgb_errors, word_errors, timeouts);
        if (rgb_errors + word_errors + timeouts == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    endtask

    // returns on the clk edge where the dut sees pxl_cen high
    task automatic wait_cen();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!pxl_cen && n < cen_timeout);
        if (!pxl_cen) begin
            timeouts++;
            $display("no pxl_cen pulse seen within %0d clocks", cen_timeout);
            finish_run();
        end
    endtask

    task automatic fill_palette();
        logic [pal_aw-1:0] addr;
        for (int a = 0; a < (1 << pal_aw); a++) begin
            addr = a[pal_aw-1:0];
            @(posedge clk);
            pal_cs   <= 1'b1;
            cpu_addr <= addr;
            cpu_dout <= fill_word(addr);
            dsn      <= 2'b00;               // both lanes
            pal_model[addr] = fill_word(addr);
        end
        @(posedge clk);
        pal_cs <= 1'b0;
        dsn    <= 2'b11;
    endtask

    task automatic cpu_write_read(input int n);
        logic [31:0]       rnd;
        logic [pal_aw-1:0] addr;
        logic [pal_dw-1:0] data;
        logic [1:0]        strobes;
        for (int i = 0; i < n; i++) begin
            rnd = $urandom;
            addr = rnd[pal_aw-1:0];
            rnd = $urandom;
            data = rnd[pal_dw-1:0];
            strobes = rnd[17:16];            // 11 = no lane written
            @(posedge clk);
            pal_cs   <= 1'b1;
            cpu_addr <= addr;
            cpu_dout <= data;
            dsn      <= strobes;
            @(posedge clk);                  // write lands here
            pal_cs <= 1'b0;
            dsn    <= 2'b11;
            if (!strobes[0])
                pal_model[addr][7:0] = data[7:0];
            if (!strobes[1])
                pal_model[addr][15:8] = data[15:8];
            @(posedge clk);                  // new word read out
            @(negedge clk);
            check_word(cpu_din, pal_model[addr], addr);
        end
    endtask

    // mode 0 plain, 1 random gfx_en, 2 shadow objects, 3 blanking and video_en
    task automatic drive_pixel(input int mode);
        logic [31:0]       rnd;
        logic [char_w-1:0] ch;
        logic [scr_w-1:0]  s1;
        logic [scr_w-1:0]  s2;
        logic [obj_w-1:0]  ob;
        logic [3:0]        en;
        logic              ven;
        logic              hb;
        logic              vb;
        rnd = $urandom;
        ch = rnd[char_w-1:0];
        ob = rnd[31:20];
        rnd = $urandom;
        s1 = rnd[scr_w-1:0];
        s2 = rnd[26:16];
        if ($urandom_range(3) == 0) ch[3:0] = 4'd0;   // transparent now and then
        if ($urandom_range(3) == 0) s1[3:0] = 4'd0;
        if ($urandom_range(3) == 0) ob[3:0] = 4'd0;
        en = 4'hf;
        ven = 1'b1;
        hb = 1'b1;
        vb = 1'b1;
        case (mode)
            1: begin
                rnd = $urandom;
                en = rnd[3:0];
            end
            2: begin
                ob[9:4] = shadow_code;
                if (ob[3:0] == 4'd0)
                    ob[3:0] = 4'h9;
            end
            3: begin
                ven = ($urandom_range(3) != 0);
                hb = ($urandom_range(3) != 0);
                vb = ($urandom_range(3) != 0);
            end
            default: ;
        endcase
        char_pxl <= ch;
        scr1_pxl <= s1;
        scr2_pxl <= s2;
        obj_pxl  <= ob;
        gfx_en   <= en;
        video_en <= ven;                     // gates the pixel already in flight
        LHBL     <= hb;
        LVBL     <= vb;
        if (have_prev)
            exp_q.push_back(gate_pixel(prev_raw, ven));
        prev_raw = model_pixel(ch, s1, s2, ob, en, hb, vb);
        have_prev = 1'b1;
    endtask

    task automatic run_pixels(input int n, input int mode);
        pix_t expd;
        exp_q.delete();
        have_prev = 1'b0;
        for (int i = 0; i < n; i++) begin
            wait_cen();
            drive_pixel(mode);
            @(negedge clk);
            if (exp_q.size() > blank_dly) begin   // input register plus the delay line
                expd = exp_q.pop_front();
                check_rgb(expd.r, expd.g, expd.b, expd.hb, expd.vb);
            end
        end
    endtask

    initial begin
        void'($urandom(79));
        rst_n       = 1'b0;
        video_en    = 1'b0;
        gfx_en      = 4'h0;
        LHBL        = 1'b0;
        LVBL        = 1'b0;
        pal_cs      = 1'b0;
        cpu_addr    = '0;
        cpu_dout    = '0;
        dsn         = 2'b11;
        char_pxl    = '0;
        scr1_pxl    = '0;
        scr2_pxl    = '0;
        obj_pxl     = '0;
        have_prev   = 1'b0;
        rgb_errors  = 0;
        word_errors = 0;
        timeouts    = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_rgb('0, '0, '0, 1'b0, 1'b0);   // blanked out of reset
        fill_palette();
        cpu_write_read(64);
        run_pixels(300, 0);
        run_pixels(300, 1);
        run_pixels(300, 2);
        run_pixels(300, 3);
        cpu_write_read(16);
        run_pixels(200, 2);
        finish_run();
    end

endmodule

//--- compile.f
colmix_pkg.sv
layer_prio.sv
pal_ram.sv
shade_blank.sv
colmix.sv
colmix_properties.sv
colmix_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the colour mixer testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module colmix_tb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vcolmix_tb)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
